//--- osd_char_buffer.sv
`default_nettype none

module osd_char_buffer (
    input  wire                        clk_video,
    input  wire osd_cmd_pkg::buf_wr_t  wr,
    input  wire osd_cmd_pkg::buf_addr_t rd_addr,
    output osd_cmd_pkg::byte_t         rd_data
);

    // One entry per address, 16 lines of 32 columns
    localparam int DEPTH = 2 ** $bits(osd_cmd_pkg::buf_addr_t);

    osd_cmd_pkg::byte_t mem [DEPTH];

    // Write side, fed by the command decoder
    always_ff @(posedge clk_video) begin
        if (wr.en) begin
            mem[wr.addr] <= wr.data;
        end
    end

    // Read side for the renderer
    // data comes back the cycle after the address
    always_ff @(posedge clk_video) begin
        rd_data <= mem[rd_addr];
    end

endmodule

`default_nettype wire

//--- osd_cmd_decoder.sv
`default_nettype none

module osd_cmd_decoder (
    input  wire                      clk_video,
    input  wire                      rst_n,
    input  wire osd_cmd_pkg::byte_t  cmd_byte,
    input  wire                      cmd_valid,
    input  wire                      cmd_cs_n,
    output osd_cmd_pkg::buf_wr_t     buf_wr,
    output logic                     osd_enable,
    output osd_cmd_pkg::ctrl_regs_t  ctrl
);

    osd_cmd_pkg::cmd_state_e state;
    osd_cmd_pkg::line_t      line_num;
    osd_cmd_pkg::col_t       char_cnt;

    // Byte counts only inside a frame
    logic byte_take;
    // Any byte 0x20..0x2F selects a line write
    logic is_line_write;

    assign byte_take     = cmd_valid && !cmd_cs_n;
    assign is_line_write = (cmd_byte & 8'hF0) == osd_cmd_pkg::CMD_OSD_WRITE_BASE;

    // ==========================================================
    // Command FSM
    // ==========================================================
    always_ff @(posedge clk_video or negedge rst_n) begin
        if (!rst_n) begin
            state      <= osd_cmd_pkg::ST_IDLE;
            line_num   <= '0;
            char_cnt   <= '0;
            buf_wr     <= '0;
            osd_enable <= 1'b0;
            ctrl       <= '0;
        end else begin
            // Write strobe lasts one cycle
            buf_wr.en <= 1'b0;

            if (byte_take) begin
                unique case (state)
                    osd_cmd_pkg::ST_IDLE: begin
                        unique case (cmd_byte)
                            osd_cmd_pkg::CMD_OSD_DISABLE: osd_enable <= 1'b0;
                            osd_cmd_pkg::CMD_OSD_ENABLE:  osd_enable <= 1'b1;
                            osd_cmd_pkg::CMD_JOYSTICK_0:  state <= osd_cmd_pkg::ST_JOY0_LO;
                            osd_cmd_pkg::CMD_JOYSTICK_1:  state <= osd_cmd_pkg::ST_JOY1_LO;
                            osd_cmd_pkg::CMD_STATUS:      state <= osd_cmd_pkg::ST_STATUS_0;
                            default: begin
                                // Unknown codes leave the decoder in idle
                                if (is_line_write) begin
                                    line_num <= cmd_byte[3:0];
                                    char_cnt <= '0;
                                    state    <= osd_cmd_pkg::ST_OSD_DATA;
                                end
                            end
                        endcase
                    end

                    osd_cmd_pkg::ST_OSD_DATA: begin
                        buf_wr.en   <= 1'b1;
                        buf_wr.addr <= {line_num, char_cnt};
                        buf_wr.data <= cmd_byte;
                        // Column counter wraps back to 0 after 31
                        char_cnt    <= char_cnt + 1'b1;
                        if (char_cnt == '1) begin
                            state <= osd_cmd_pkg::ST_IDLE;
                        end
                    end

                    // Joystick words, low byte first
                    osd_cmd_pkg::ST_JOY0_LO: begin
                        ctrl.joystick_0[7:0] <= cmd_byte;
                        state <= osd_cmd_pkg::ST_JOY0_HI;
                    end
                    osd_cmd_pkg::ST_JOY0_HI: begin
                        ctrl.joystick_0[15:8] <= cmd_byte;
                        state <= osd_cmd_pkg::ST_IDLE;
                    end
                    osd_cmd_pkg::ST_JOY1_LO: begin
                        ctrl.joystick_1[7:0] <= cmd_byte;
                        state <= osd_cmd_pkg::ST_JOY1_HI;
                    end
                    osd_cmd_pkg::ST_JOY1_HI: begin
                        ctrl.joystick_1[15:8] <= cmd_byte;
                        state <= osd_cmd_pkg::ST_IDLE;
                    end

                    // Status word, four bytes, LSB first
                    osd_cmd_pkg::ST_STATUS_0: begin
                        ctrl.status[7:0] <= cmd_byte;
                        state <= osd_cmd_pkg::ST_STATUS_1;
                    end
                    osd_cmd_pkg::ST_STATUS_1: begin
                        ctrl.status[15:8] <= cmd_byte;
                        state <= osd_cmd_pkg::ST_STATUS_2;
                    end
                    osd_cmd_pkg::ST_STATUS_2: begin
                        ctrl.status[23:16] <= cmd_byte;
                        state <= osd_cmd_pkg::ST_STATUS_3;
                    end
                    osd_cmd_pkg::ST_STATUS_3: begin
                        ctrl.status[31:24] <= cmd_byte;
                        state <= osd_cmd_pkg::ST_IDLE;
                    end

                    default: state <= osd_cmd_pkg::ST_IDLE;
                endcase
            end

            // End of frame drops any half-finished sequence
            if (cmd_cs_n) begin
                state <= osd_cmd_pkg::ST_IDLE;
            end
        end
    end

endmodule

`default_nettype wire

//--- osd_cmd_pkg.sv
`default_nettype none

package osd_cmd_pkg;

    // ==========================================================
    // Byte stream and character buffer types
    // ==========================================================

    // One command or data byte from the host stream
    typedef logic [7:0] byte_t;

    // Buffer address is {line, column}
    typedef logic [8:0] buf_addr_t;
    typedef logic [3:0] line_t;
    typedef logic [4:0] col_t;

    // Single write into the character buffer
    typedef struct packed {
        logic      en;
        buf_addr_t addr;
        byte_t     data;
    } buf_wr_t;

    // Words assembled from the host for the core
    typedef struct packed {
        logic [31:0] status;
        logic [15:0] joystick_0;
        logic [15:0] joystick_1;
    } ctrl_regs_t;

    // ==========================================================
    // Command codes
    // ==========================================================
    localparam byte_t CMD_OSD_DISABLE    = 8'h40;
    localparam byte_t CMD_OSD_ENABLE     = 8'h41;
    // Low nibble carries the line number
    localparam byte_t CMD_OSD_WRITE_BASE = 8'h20;
    localparam byte_t CMD_JOYSTICK_0     = 8'h02;
    localparam byte_t CMD_JOYSTICK_1     = 8'h03;
    localparam byte_t CMD_STATUS         = 8'h1E;

    // Decoder states, one step per accepted byte
    typedef enum logic [3:0] {
        ST_IDLE,
        ST_OSD_DATA,
        ST_JOY0_LO,
        ST_JOY0_HI,
        ST_JOY1_LO,
        ST_JOY1_HI,
        ST_STATUS_0,
        ST_STATUS_1,
        ST_STATUS_2,
        ST_STATUS_3
    } cmd_state_e;

endpackage

`default_nettype wire

//--- osd_overlay_patterns.txt
# Tags: R de hs vs | B byte | F count byte | C pulses cs_n | K status joy0 joy1
# P x y rgb_in rgb_expected | D x y random input, expect half brightness; all hex
R 0 1 1
K 00000000 0000 0000
B 02
B 34
B 12
B 03
B cd
B ab
B 1e
B 78
B 56
B 34
B 12
K 12345678 1234 abcd
B 77
K 12345678 1234 abcd
B 22
F 20 a5
B 41
P 190 150 123456 ff0000
D 190 151
P 190 155 0f0f0f ff0000
D 1f0 156
P 27f 157 808080 ff0000
P 280 150 abcdef abcdef
P 17f 150 fedcba fedcba
P 190 13f 55aa55 55aa55
B 40
P 190 150 123456 123456
P 1f0 151 a0b0c0 a0b0c0
B 1e
B ef
B be
C
B 02
B 11
B 22
K 1234beef 2211 abcd

//--- osd_overlay_top.f
osd_cmd_pkg.sv
osd_video_pkg.sv
osd_cmd_decoder.sv
osd_char_buffer.sv
osd_renderer.sv
osd_video_mixer.sv
osd_overlay_top.sv
tb_osd_overlay_top.sv

//--- osd_overlay_top.sv
`default_nettype none

module osd_overlay_top #(
    parameter osd_video_pkg::osd_color_t OSD_COLOR    = 3'd4,
    parameter osd_video_pkg::coord_t     OSD_X_OFFSET = 12'd384,
    parameter osd_video_pkg::coord_t     OSD_Y_OFFSET = 12'd320
) (
    input  wire                             clk_video,
    input  wire                             rst_n,
    // Framed host byte stream
    input  wire osd_cmd_pkg::byte_t         cmd_byte,
    input  wire                             cmd_valid,
    input  wire                             cmd_cs_n,
    // Video from the core
    input  wire osd_video_pkg::video_bus_t  video_in,
    input  wire osd_video_pkg::coord_t      pixel_x,
    input  wire osd_video_pkg::coord_t      pixel_y,
    // Video with overlay, three cycles later
    output osd_video_pkg::video_bus_t       video_out,
    output osd_cmd_pkg::ctrl_regs_t         ctrl
);

    osd_cmd_pkg::buf_wr_t   buf_wr;
    osd_cmd_pkg::buf_addr_t rd_addr;
    osd_cmd_pkg::byte_t     rd_data;
    logic                   osd_enable;
    logic                   osd_visible;
    logic                   osd_pixel;

    // ==========================================================
    // Command path
    // ==========================================================
    osd_cmd_decoder u_cmd_decoder (
        .clk_video  (clk_video),
        .rst_n      (rst_n),
        .cmd_byte   (cmd_byte),
        .cmd_valid  (cmd_valid),
        .cmd_cs_n   (cmd_cs_n),
        .buf_wr     (buf_wr),
        .osd_enable (osd_enable),
        .ctrl       (ctrl)
    );

    osd_char_buffer u_char_buffer (
        .clk_video (clk_video),
        .wr        (buf_wr),
        .rd_addr   (rd_addr),
        .rd_data   (rd_data)
    );

    // ==========================================================
    // Video path
    // ==========================================================
    osd_renderer #(
        .OSD_X_OFFSET (OSD_X_OFFSET),
        .OSD_Y_OFFSET (OSD_Y_OFFSET)
    ) u_renderer (
        .clk_video   (clk_video),
        .rst_n       (rst_n),
        .pixel_x     (pixel_x),
        .pixel_y     (pixel_y),
        .osd_enable  (osd_enable),
        .rd_addr     (rd_addr),
        .rd_data     (rd_data),
        .osd_visible (osd_visible),
        .osd_pixel   (osd_pixel)
    );

    osd_video_mixer #(
        .OSD_COLOR (OSD_COLOR)
    ) u_video_mixer (
        .clk_video   (clk_video),
        .rst_n       (rst_n),
        .video_in    (video_in),
        .osd_visible (osd_visible),
        .osd_pixel   (osd_pixel),
        .video_out   (video_out)
    );

endmodule

`default_nettype wire

//--- osd_renderer.sv
`default_nettype none

module osd_renderer #(
    parameter osd_video_pkg::coord_t OSD_X_OFFSET = 12'd384,
    parameter osd_video_pkg::coord_t OSD_Y_OFFSET = 12'd320
) (
    input  wire                         clk_video,
    input  wire                         rst_n,
    input  wire osd_video_pkg::coord_t  pixel_x,
    input  wire osd_video_pkg::coord_t  pixel_y,
    input  wire                         osd_enable,
    output osd_cmd_pkg::buf_addr_t      rd_addr,
    input  wire osd_cmd_pkg::byte_t     rd_data,
    output logic                        osd_visible,
    output logic                        osd_pixel
);

    // Bit index within a buffer byte
    localparam int ROW_W = $clog2(osd_video_pkg::LINE_ROWS);

    // Position relative to the window corner
    osd_video_pkg::coord_t x_rel;
    osd_video_pkg::coord_t y_rel;
    logic                  in_window;

    logic             visible_s1;
    logic             visible_s2;
    logic [ROW_W-1:0] row_s1;
    logic [ROW_W-1:0] row_s2;

    // ==========================================================
    // Stage 1 window test and buffer address
    // ==========================================================
    assign x_rel = pixel_x - OSD_X_OFFSET;
    assign y_rel = pixel_y - OSD_Y_OFFSET;

    assign in_window = (pixel_x >= OSD_X_OFFSET) && (x_rel < osd_video_pkg::OSD_WIDTH)
                    && (pixel_y >= OSD_Y_OFFSET) && (y_rel < osd_video_pkg::OSD_HEIGHT);

    // Visibility flags
    always_ff @(posedge clk_video or negedge rst_n) begin
        if (!rst_n) begin
            visible_s1 <= 1'b0;
            visible_s2 <= 1'b0;
        end else begin
            visible_s1 <= in_window && osd_enable;
            // Follows the RAM read
            visible_s2 <= visible_s1;
        end
    end

    // Address is {text line, column}
    always_ff @(posedge clk_video) begin
        rd_addr <= {osd_cmd_pkg::line_t'(y_rel / osd_video_pkg::LINE_ROWS),
                    osd_cmd_pkg::col_t'(x_rel / osd_video_pkg::CHAR_COL_PIXELS)};
        row_s1  <= ROW_W'(y_rel % osd_video_pkg::LINE_ROWS);
        row_s2  <= row_s1;
    end

    // ==========================================================
    // Stage 2 pixel bit select
    // ==========================================================
    // Bit n of the byte lights row n of the text line
    assign osd_visible = visible_s2;
    assign osd_pixel   = visible_s2 && rd_data[row_s2];

endmodule

`default_nettype wire

//--- osd_video_mixer.sv
`default_nettype none

module osd_video_mixer #(
    parameter osd_video_pkg::osd_color_t OSD_COLOR = 3'd4
) (
    input  wire                             clk_video,
    input  wire                             rst_n,
    input  wire osd_video_pkg::video_bus_t  video_in,
    input  wire                             osd_visible,
    input  wire                             osd_pixel,
    output osd_video_pkg::video_bus_t       video_out
);

    // Blanked bus with inactive sync, used at reset
    localparam osd_video_pkg::video_bus_t VIDEO_IDLE = '{
        rgb: '0,
        de:  1'b0,
        hs:  1'b1,
        vs:  1'b1
    };

    // Colour code spread to full channels
    localparam osd_video_pkg::rgb_t FG_RGB = {
        {8{OSD_COLOR[2]}},
        {8{OSD_COLOR[1]}},
        {8{OSD_COLOR[0]}}
    };

    osd_video_pkg::video_bus_t video_d1;
    osd_video_pkg::video_bus_t video_d2;
    osd_video_pkg::rgb_t       dim_rgb;
    osd_video_pkg::rgb_t       mixed_rgb;

    // ==========================================================
    // Delay line matching the renderer
    // ==========================================================
    always_ff @(posedge clk_video or negedge rst_n) begin
        if (!rst_n) begin
            video_d1 <= VIDEO_IDLE;
            video_d2 <= VIDEO_IDLE;
        end else begin
            video_d1 <= video_in;
            video_d2 <= video_d1;
        end
    end

    // Half brightness behind the text
    // each channel shifted right by one
    assign dim_rgb = {1'b0, video_d2.rgb[23:17],
                      1'b0, video_d2.rgb[15:9],
                      1'b0, video_d2.rgb[7:1]};

    // ==========================================================
    // Colour selection and output register
    // ==========================================================
    always_comb begin
        if (osd_visible && osd_pixel) begin
            mixed_rgb = FG_RGB;
        end else if (osd_visible) begin
            mixed_rgb = dim_rgb;
        end else begin
            // Outside the window
            mixed_rgb = video_d2.rgb;
        end
    end

    // Sync leaves together with its pixel
    always_ff @(posedge clk_video or negedge rst_n) begin
        if (!rst_n) begin
            video_out <= VIDEO_IDLE;
        end else begin
            video_out <= '{rgb: mixed_rgb, de: video_d2.de, hs: video_d2.hs, vs: video_d2.vs};
        end
    end

endmodule

`default_nettype wire

//--- osd_video_pkg.sv
`default_nettype none

package osd_video_pkg;

    // ==========================================================
    // Pixel and colour types
    // ==========================================================

    // Screen coordinate, wide enough for 4K timings
    typedef logic [11:0] coord_t;

    // 8 bits per channel, red on top, blue at the bottom
    typedef logic [23:0] rgb_t;

    // Foreground colour code
    // bit 2 red, bit 1 green, bit 0 blue
    typedef logic [2:0] osd_color_t;

    // Pixel with its timing strobes
    typedef struct packed {
        rgb_t rgb;
        logic de;
        logic hs;
        logic vs;
    } video_bus_t;

    // ==========================================================
    // OSD window geometry
    // ==========================================================

    // Window size in pixels
    localparam coord_t OSD_WIDTH  = 12'd256;
    localparam coord_t OSD_HEIGHT = 12'd128;

    // One buffer byte spans this many pixels across
    localparam coord_t CHAR_COL_PIXELS = 12'd8;

    // Rows per text line, one per bit of a buffer byte
    localparam coord_t LINE_ROWS = 12'd8;

    // 256 / 8 = 32 columns, 128 / 8 = 16 lines
    // which fills the 512-byte buffer exactly

endpackage

`default_nettype wire

//--- tb_osd_overlay_top.sv
`default_nettype none

module tb_osd_overlay_top;

    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 8;
    // Cycles from video_in to video_out
    localparam int PIPE_DEPTH   = 3;
    // Pipeline is 3 deep, so 10 cycles is generous
    localparam int DE_TIMEOUT   = 10;

    logic                      clk_video;
    logic                      rst_n;
    osd_cmd_pkg::byte_t        cmd_byte;
    logic                      cmd_valid;
    logic                      cmd_cs_n;
    osd_video_pkg::video_bus_t video_in;
    osd_video_pkg::coord_t     pixel_x;
    osd_video_pkg::coord_t     pixel_y;
    osd_video_pkg::video_bus_t video_out;
    osd_cmd_pkg::ctrl_regs_t   ctrl;

    int     pass_count;
    int     fail_count;
    integer seed;

    // Pattern file fields
    integer            fd;
    integer            rc;
    logic [8*8-1:0]    tag;
    logic [8*160-1:0]  rest;
    logic [31:0]       f_a;
    logic [31:0]       f_b;
    logic [31:0]       f_c;
    logic [31:0]       f_d;
    osd_video_pkg::rgb_t rnd_rgb;

    osd_overlay_top uut (
        .clk_video (clk_video),
        .rst_n     (rst_n),
        .cmd_byte  (cmd_byte),
        .cmd_valid (cmd_valid),
        .cmd_cs_n  (cmd_cs_n),
        .video_in  (video_in),
        .pixel_x   (pixel_x),
        .pixel_y   (pixel_y),
        .video_out (video_out),
        .ctrl      (ctrl)
    );

    initial begin
        clk_video = 1'b0;
        forever #(CLK_PERIOD / 2) clk_video = ~clk_video;
    end

    // ============================================================
    // Compare tasks
    // ============================================================
    task automatic check_rgb(input osd_video_pkg::coord_t x, input osd_video_pkg::coord_t y,
                             input osd_video_pkg::rgb_t got, input osd_video_pkg::rgb_t exp);
        if (got !== exp) begin
            $display("** Error at %0t: pixel (%0d, %0d) rgb %h, expected %h",
                     $time, x, y, got, exp);
            fail_count++;
        end else begin
            $display("ok    pixel (%0d, %0d) rgb %h", x, y, got);
            pass_count++;
        end
    endtask

    task automatic check_ctrl(input osd_cmd_pkg::ctrl_regs_t got,
                              input osd_cmd_pkg::ctrl_regs_t exp);
        if (got !== exp) begin
            $display("** Error at %0t: ctrl status %h joy0 %h joy1 %h, expected %h %h %h",
                     $time, got.status, got.joystick_0, got.joystick_1,
                     exp.status, exp.joystick_0, exp.joystick_1);
            fail_count++;
        end else begin
            $display("ok    ctrl status %h joy0 %h joy1 %h",
                     got.status, got.joystick_0, got.joystick_1);
            pass_count++;
        end
    endtask

    // Only the timing strobes matter here
    task automatic check_sync(input osd_video_pkg::video_bus_t got,
                              input osd_video_pkg::video_bus_t exp);
        if ({got.de, got.hs, got.vs} !== {exp.de, exp.hs, exp.vs}) begin
            $display("** Error at %0t: de/hs/vs %b%b%b, expected %b%b%b",
                     $time, got.de, got.hs, got.vs, exp.de, exp.hs, exp.vs);
            fail_count++;
        end else begin
            $display("ok    sync de %b hs %b vs %b", got.de, got.hs, got.vs);
            pass_count++;
        end
    endtask

    // ============================================================
    // Stimulus helpers
    // ============================================================
    task automatic send_byte(input osd_cmd_pkg::byte_t b);
        @(negedge clk_video);
        cmd_byte  = b;
        cmd_valid = 1'b1;
        @(negedge clk_video);
        cmd_valid = 1'b0;
    endtask

    // Close the frame for one cycle
    task automatic pulse_cs;
        @(negedge clk_video);
        cmd_cs_n = 1'b1;
        @(negedge clk_video);
        cmd_cs_n = 1'b0;
    endtask

    // Each channel halved, low bit dropped
    function automatic osd_video_pkg::rgb_t half_bright(input osd_video_pkg::rgb_t c);
        return {c[23:16] >> 1, c[15:8] >> 1, c[7:0] >> 1};
    endfunction

    // One active pixel between blanked cycles
    // Sync levels follow the coordinate LSBs so both levels reach the output
    task automatic probe_pixel(input osd_video_pkg::coord_t x, input osd_video_pkg::coord_t y,
                               input osd_video_pkg::rgb_t rgb_in, input osd_video_pkg::rgb_t exp);
        int wait_cnt;
        osd_video_pkg::video_bus_t exp_bus;
        exp_bus = '{rgb: exp, de: 1'b1, hs: x[0], vs: y[0]};
        @(negedge clk_video);
        pixel_x  = x;
        pixel_y  = y;
        video_in = '{rgb: rgb_in, de: 1'b1, hs: x[0], vs: y[0]};
        @(negedge clk_video);
        pixel_x  = '0;
        pixel_y  = '0;
        video_in = '{rgb: '0, de: 1'b0, hs: 1'b1, vs: 1'b1};
        wait_cnt = 0;
        while (!video_out.de && wait_cnt < DE_TIMEOUT) begin
            @(negedge clk_video);
            wait_cnt++;
        end
        if (!video_out.de) begin
            $display("Timeout at %0t: de_out never arrived for pixel (%0d, %0d)", $time, x, y);
            fail_count++;
        end else if (wait_cnt + 1 != PIPE_DEPTH) begin
            $display("Pixel (%0d, %0d) came out after %0d cycles instead of %0d",
                     x, y, wait_cnt + 1, PIPE_DEPTH);
            fail_count++;
        end else begin
            check_rgb(x, y, video_out.rgb, exp);
            check_sync(video_out, exp_bus);
        end
    endtask

    // ============================================================
    // Main sequence
    // ============================================================
    initial begin
        pass_count = 0;
        fail_count = 0;
        seed       = 32'ha552cb2c;
        rst_n      = 1'b0;
        cmd_byte   = '0;
        cmd_valid  = 1'b0;
        cmd_cs_n   = 1'b0;
        pixel_x    = '0;
        pixel_y    = '0;
        video_in   = '{rgb: '0, de: 1'b0, hs: 1'b1, vs: 1'b1};
        repeat (RESET_CYCLES) @(negedge clk_video);
        rst_n = 1'b1;

        fd = $fopen("osd_overlay_patterns.txt", "r");
        if (fd == 0) begin
            $display("Could not open the pattern file osd_overlay_patterns.txt");
            fail_count++;
        end else begin
            while ($fscanf(fd, " %s", tag) == 1) begin
                case (tag)
                    "#": rc = $fgets(rest, fd);
                    "R": begin
                        rc = $fscanf(fd, " %h %h %h", f_a, f_b, f_c);
                        check_sync(video_out, '{rgb: '0, de: f_a[0], hs: f_b[0], vs: f_c[0]});
                    end
                    "B": begin
                        rc = $fscanf(fd, " %h", f_a);
                        send_byte(f_a[7:0]);
                    end
                    "F": begin
                        rc = $fscanf(fd, " %h %h", f_a, f_b);
                        repeat (f_a) send_byte(f_b[7:0]);
                    end
                    "C": pulse_cs();
                    "K": begin
                        rc = $fscanf(fd, " %h %h %h", f_a, f_b, f_c);
                        check_ctrl(ctrl, '{status: f_a, joystick_0: f_b[15:0],
                                           joystick_1: f_c[15:0]});
                    end
                    "P": begin
                        rc = $fscanf(fd, " %h %h %h %h", f_a, f_b, f_c, f_d);
                        probe_pixel(f_a[11:0], f_b[11:0], f_c[23:0], f_d[23:0]);
                    end
                    "D": begin
                        rc = $fscanf(fd, " %h %h", f_a, f_b);
                        rnd_rgb = osd_video_pkg::rgb_t'($random(seed));
                        probe_pixel(f_a[11:0], f_b[11:0], rnd_rgb, half_bright(rnd_rgb));
                    end
                    default: begin
                        $display("Unknown step in the pattern file, skipping the line");
                        rc = $fgets(rest, fd);
                        fail_count++;
                    end
                endcase
            end
            $fclose(fd);
        end

        $display("Checks passed: %0d, failed: %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire
